// ==== Makefile ====
# Verilator build and run of the L1 instruction cache testbench

VERILATOR ?= verilator
TOP       ?= tb_l1i_cache
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM  := $(BUILD_DIR)/V$(TOP)
SRCS := $(wildcard src/*.sv verif/*.sv verif/*.svh)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -qx "test passed" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sources.f ====
+incdir+verif
src/mem_types_pkg.sv
src/l1i_pkg.sv
src/l1i_req_stage.sv
src/l1i_lookup_stage.sv
src/l1i_resp_stage.sv
src/l1i_cache.sv
verif/tb_l1i_cache.sv

// ==== src/l1i_cache.sv ====
`timescale 1ns/1ps

module l1i_cache #(
  parameter int NUM_LINES = 24
) (
  input  logic                    clk_in,
  input  logic                    rst_N_in,
  input  logic                    flush_in,

  // fetch side
  input  logic                    l0_valid_in,
  input  mem_types_pkg::paddr_u   l0_addr_in,
  output logic                    l0_ready_out,
  output logic                    l0_valid_out,
  output mem_types_pkg::paddr_u   l0_addr_out,
  output mem_types_pkg::line_t    l0_value_out,
  input  logic                    l0_ready_in,

  // llc side
  output logic                    lc_valid_out,
  output mem_types_pkg::llc_req_t lc_addr_out,
  input  logic                    lc_ready_in,
  input  logic                    lc_valid_in,
  input  mem_types_pkg::paddr_u   lc_addr_in,
  input  mem_types_pkg::line_t    lc_value_in,
  output logic                    lc_ready_out
);

  logic                     s1_valid;
  l1i_pkg::fetch_req_t      s1_req;
  logic                     s2_take;
  logic                     s2_valid;
  l1i_pkg::lookup_t         s2_res;
  logic                     s3_take;
  logic                     fill_we;
  mem_types_pkg::llc_fill_t fill;

  l1i_req_stage u_req (
    .clk_in       (clk_in),
    .rst_N_in     (rst_N_in),
    .l0_valid_in  (l0_valid_in),
    .l0_addr_in   (l0_addr_in),
    .s2_take      (s2_take),
    .l0_ready_out (l0_ready_out),
    .s1_valid     (s1_valid),
    .s1_req       (s1_req)
  );

  l1i_lookup_stage #(
    .NUM_LINES (NUM_LINES)
  ) u_lookup (
    .clk_in   (clk_in),
    .rst_N_in (rst_N_in),
    .flush_in (flush_in),
    .s1_valid (s1_valid),
    .s1_req   (s1_req),
    .s3_take  (s3_take),
    .fill_we  (fill_we),
    .fill     (fill),
    .s2_take  (s2_take),
    .s2_valid (s2_valid),
    .s2_res   (s2_res)
  );

  l1i_resp_stage u_resp (
    .clk_in       (clk_in),
    .rst_N_in     (rst_N_in),
    .s2_valid     (s2_valid),
    .s2_res       (s2_res),
    .l0_ready_in  (l0_ready_in),
    .lc_ready_in  (lc_ready_in),
    .lc_valid_in  (lc_valid_in),
    .lc_addr_in   (lc_addr_in),
    .lc_value_in  (lc_value_in),
    .s3_take      (s3_take),
    .fill_we      (fill_we),
    .fill         (fill),
    .l0_valid_out (l0_valid_out),
    .l0_addr_out  (l0_addr_out),
    .l0_value_out (l0_value_out),
    .lc_valid_out (lc_valid_out),
    .lc_addr_out  (lc_addr_out),
    .lc_ready_out (lc_ready_out)
  );

endmodule

// ==== src/l1i_lookup_stage.sv ====
`timescale 1ns/1ps

module l1i_lookup_stage #(
  parameter int NUM_LINES = 24
) (
  input  logic                     clk_in,
  input  logic                     rst_N_in,
  input  logic                     flush_in,
  input  logic                     s1_valid,
  input  l1i_pkg::fetch_req_t      s1_req,
  input  logic                     s3_take,
  input  logic                     fill_we,
  input  mem_types_pkg::llc_fill_t fill,
  output logic                     s2_take,
  output logic                     s2_valid,
  output l1i_pkg::lookup_t         s2_res
);

  localparam int LN_BITS  = mem_types_pkg::PADDR_BITS - mem_types_pkg::OFFSET_BITS;
  localparam int IDX_BITS = (NUM_LINES > 1) ? $clog2(NUM_LINES) : 1;
  // line_num / NUM_LINES needs LN_BITS minus floor(log2(NUM_LINES)) bits
  localparam int TAG_BITS = LN_BITS - $clog2(NUM_LINES + 1) + 1;
  localparam logic [LN_BITS-1:0] NL = LN_BITS'(NUM_LINES);

  function automatic logic [IDX_BITS-1:0] index_of(mem_types_pkg::paddr_u a);
    return IDX_BITS'(a.split.line_num % NL);
  endfunction

  function automatic logic [TAG_BITS-1:0] tag_of(mem_types_pkg::paddr_u a);
    return TAG_BITS'(a.split.line_num / NL);
  endfunction

  logic [NUM_LINES-1:0]  valid_bits;
  logic [TAG_BITS-1:0]   tag_mem  [NUM_LINES];
  mem_types_pkg::line_t  data_mem [NUM_LINES];

  logic                  h_valid;  // an item sits in this stage
  mem_types_pkg::paddr_u h_addr;
  logic                  take_new;
  logic [IDX_BITS-1:0]   rd_idx;
  logic [IDX_BITS-1:0]   fill_idx;

  logic                  fresh_q;  // last read saw the arrays as they are now
  logic                  rd_valid_q;
  logic [TAG_BITS-1:0]   rd_tag_q;
  mem_types_pkg::line_t  rd_data_q;

  assign s2_valid = h_valid && fresh_q;
  assign s2_take  = !h_valid || (s2_valid && s3_take);
  assign take_new = s1_valid && s2_take;

  // read for the incoming address, or keep re-reading the held one
  assign rd_idx   = take_new ? index_of(s1_req.addr) : index_of(h_addr);
  assign fill_idx = index_of(fill.addr);

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      h_valid <= 1'b0;
      fresh_q <= 1'b0;
    end else begin
      if (s2_take) begin
        h_valid <= s1_valid;
      end
      // a write at this edge makes the read just taken stale
      fresh_q <= !(fill_we || flush_in);
    end
  end

  always_ff @(posedge clk_in) begin
    if (take_new) begin
      h_addr <= s1_req.addr;
    end
  end

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      valid_bits <= '0;
    end else begin
      if (flush_in) begin
        valid_bits <= '0;
      end
      if (fill_we) begin
        valid_bits[fill_idx] <= 1'b1;  // wins over a flush in the same cycle
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (fill_we) begin
      tag_mem[fill_idx]  <= tag_of(fill.addr);
      data_mem[fill_idx] <= fill.data;
    end
  end

  // synchronous array read
  always_ff @(posedge clk_in) begin
    rd_valid_q <= valid_bits[rd_idx];
    rd_tag_q   <= tag_mem[rd_idx];
    rd_data_q  <= data_mem[rd_idx];
  end

  always_comb begin
    s2_res.addr = h_addr;
    s2_res.hit  = rd_valid_q && (rd_tag_q == tag_of(h_addr));
    s2_res.data = rd_data_q;
  end

  // once the fill has been re-read, the line it evicted must not hit
  a_no_stale_hit: assert property (
    @(posedge clk_in) disable iff (!rst_N_in)
    $past(fill_we, 2) |-> !(s2_valid && s2_res.hit &&
                            index_of(s2_res.addr) == index_of($past(fill.addr, 2)) &&
                            tag_of(s2_res.addr) != tag_of($past(fill.addr, 2)))
  );

endmodule

// ==== src/l1i_pkg.sv ====
package l1i_pkg;

  // request payload moving from the req stage into lookup
  typedef struct packed {
    mem_types_pkg::paddr_u addr;
  } fetch_req_t;

  // lookup result handed to the response stage
  typedef struct packed {
    mem_types_pkg::paddr_u addr;
    logic                  hit;
    mem_types_pkg::line_t  data;  // meaningful only when hit is set
  } lookup_t;

  // response stage FSM
  typedef enum logic [1:0] {
    IDLE,
    SEND_REQ,   // miss request held toward the llc
    WAIT_FILL,  // waiting for the line to come back
    SEND_RESP   // line held toward l0
  } resp_state_e;

endpackage

// ==== src/l1i_req_stage.sv ====
`timescale 1ns/1ps

module l1i_req_stage (
  input  logic                  clk_in,
  input  logic                  rst_N_in,
  input  logic                  l0_valid_in,
  input  mem_types_pkg::paddr_u l0_addr_in,
  input  logic                  s2_take,
  output logic                  l0_ready_out,
  output logic                  s1_valid,
  output l1i_pkg::fetch_req_t   s1_req
);

  logic                ready_q;  // low through reset, high from the next cycle on
  logic                held_valid;
  l1i_pkg::fetch_req_t held_req;
  logic                load;

  // a new request may enter while the old one moves on
  assign l0_ready_out = ready_q && (!held_valid || s2_take);
  assign load         = l0_valid_in && l0_ready_out;

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      ready_q    <= 1'b0;
      held_valid <= 1'b0;
    end else begin
      ready_q <= 1'b1;
      if (load) begin
        held_valid <= 1'b1;
      end else if (s2_take) begin
        held_valid <= 1'b0;  // entry left for lookup
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (load) begin
      held_req.addr <= l0_addr_in;
    end
  end

  assign s1_valid = held_valid;
  assign s1_req   = held_req;

  // an offered request must not change until lookup takes it
  a_s1_stable: assert property (
    @(posedge clk_in) disable iff (!rst_N_in)
    (s1_valid && !s2_take) |=> (s1_valid && $stable(s1_req))
  );

endmodule

// ==== src/l1i_resp_stage.sv ====
`timescale 1ns/1ps

module l1i_resp_stage (
  input  logic                     clk_in,
  input  logic                     rst_N_in,
  input  logic                     s2_valid,
  input  l1i_pkg::lookup_t         s2_res,
  input  logic                     l0_ready_in,
  input  logic                     lc_ready_in,
  input  logic                     lc_valid_in,
  input  mem_types_pkg::paddr_u    lc_addr_in,
  input  mem_types_pkg::line_t     lc_value_in,
  output logic                     s3_take,
  output logic                     fill_we,
  output mem_types_pkg::llc_fill_t fill,
  output logic                     l0_valid_out,
  output mem_types_pkg::paddr_u    l0_addr_out,
  output mem_types_pkg::line_t     l0_value_out,
  output logic                     lc_valid_out,
  output mem_types_pkg::llc_req_t  lc_addr_out,
  output logic                     lc_ready_out
);

  l1i_pkg::resp_state_e  state_q;
  l1i_pkg::resp_state_e  state_d;
  mem_types_pkg::paddr_u addr_q;  // address of the fetch being served
  mem_types_pkg::line_t  data_q;
  mem_types_pkg::paddr_u req_addr;

  assign s3_take = (state_q == l1i_pkg::IDLE);

  // miss requests always go out line aligned
  always_comb begin
    req_addr             = addr_q;
    req_addr.split.offset = '0;
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      l1i_pkg::IDLE: begin
        if (s2_valid) begin
          state_d = s2_res.hit ? l1i_pkg::SEND_RESP : l1i_pkg::SEND_REQ;
        end
      end
      l1i_pkg::SEND_REQ: begin
        if (lc_ready_in) begin
          state_d = l1i_pkg::WAIT_FILL;
        end
      end
      l1i_pkg::WAIT_FILL: begin
        if (lc_valid_in) begin
          state_d = l1i_pkg::SEND_RESP;
        end
      end
      l1i_pkg::SEND_RESP: begin
        if (l0_ready_in) begin
          state_d = l1i_pkg::IDLE;
        end
      end
      default: state_d = l1i_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      state_q <= l1i_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_in) begin
    if (s3_take && s2_valid) begin
      addr_q <= s2_res.addr;
      data_q <= s2_res.data;  // overwritten by the fill on a miss
    end else if (fill_we) begin
      data_q <= lc_value_in;
    end
  end

  // the fill goes to the arrays while it is captured for l0
  assign fill_we   = (state_q == l1i_pkg::WAIT_FILL) && lc_valid_in;
  assign fill.addr = lc_addr_in;
  assign fill.data = lc_value_in;

  assign lc_valid_out = (state_q == l1i_pkg::SEND_REQ);
  assign lc_addr_out  = req_addr.word;
  assign lc_ready_out = (state_q == l1i_pkg::WAIT_FILL);

  assign l0_valid_out = (state_q == l1i_pkg::SEND_RESP);
  assign l0_addr_out  = addr_q;
  assign l0_value_out = data_q;

  // only one miss is ever outstanding, so the fill must answer it
  a_fill_addr: assert property (
    @(posedge clk_in) disable iff (!rst_N_in)
    fill_we |-> (lc_addr_in.word == req_addr.word)
  );

  a_one_side: assert property (
    @(posedge clk_in) disable iff (!rst_N_in)
    !(lc_valid_out && l0_valid_out)
  );

endmodule

// ==== src/mem_types_pkg.sv ====
package mem_types_pkg;

  // physical address and line geometry
  localparam int PADDR_BITS  = 32;
  localparam int LINE_BYTES  = 64;
  localparam int OFFSET_BITS = $clog2(LINE_BYTES);  // 6 for a 64 byte line
  localparam int LINE_BITS   = 8 * LINE_BYTES;

  // one full cache line, byte 0 in the low bits
  typedef logic [LINE_BITS-1:0] line_t;

  // an address seen as line number plus byte offset
  typedef struct packed {
    logic [PADDR_BITS-OFFSET_BITS-1:0] line_num;
    logic [OFFSET_BITS-1:0]            offset;
  } paddr_split_t;

  // the same 32 bits, either flat or split
  typedef union packed {
    logic [PADDR_BITS-1:0] word;
    paddr_split_t          split;
  } paddr_u;

  // line aligned read address toward the llc
  typedef logic [PADDR_BITS-1:0] llc_req_t;

  // a returned line together with its address
  typedef struct packed {
    paddr_u addr;
    line_t  data;
  } llc_fill_t;

endpackage

// ==== verif/l1i_ref_model.svh ====
`ifndef L1I_REF_MODEL_SVH
`define L1I_REF_MODEL_SVH

// direct mapped tag state as the testbench expects it
bit          model_valid [NUM_LINES];
int unsigned model_tag   [NUM_LINES];

// llc line content: byte b of line n holds the low 8 bits of n + b
function automatic mem_types_pkg::line_t line_pattern(input logic [25:0] line_num);
  mem_types_pkg::line_t d;
  for (int b = 0; b < mem_types_pkg::LINE_BYTES; b++) begin
    d[8*b +: 8] = 8'(line_num + 26'(b));
  end
  return d;
endfunction

// returns 1 on a predicted miss, then installs the line
function automatic bit model_access(input logic [25:0] line_num);
  int unsigned idx;
  int unsigned tag;
  bit          miss;
  idx  = line_num % NUM_LINES;
  tag  = line_num / NUM_LINES;
  miss = !(model_valid[idx] && model_tag[idx] == tag);
  model_valid[idx] = 1'b1;
  model_tag[idx]   = tag;
  return miss;
endfunction

function automatic void model_flush();
  for (int i = 0; i < NUM_LINES; i++) begin
    model_valid[i] = 1'b0;
  end
endfunction

`endif

// ==== verif/tb_l1i_cache.sv ====
`timescale 1ns/1ps

module tb_l1i_cache;

  localparam int NUM_LINES     = 24;
  localparam int CLK_PERIOD    = 4;
  localparam int RAND_FETCHES  = 60;
  localparam int TOTAL_FETCHES = 6 + RAND_FETCHES + 12;
  localparam int WATCHDOG_NS   = (TOTAL_FETCHES * 40 + 50) * CLK_PERIOD;

  logic                    clk_in;
  logic                    rst_N_in;
  logic                    flush_in;
  logic                    l0_valid_in;
  mem_types_pkg::paddr_u   l0_addr_in;
  logic                    l0_ready_out;
  logic                    l0_valid_out;
  mem_types_pkg::paddr_u   l0_addr_out;
  mem_types_pkg::line_t    l0_value_out;
  logic                    l0_ready_in;
  logic                    lc_valid_out;
  mem_types_pkg::llc_req_t lc_addr_out;
  logic                    lc_ready_in;
  logic                    lc_valid_in;
  mem_types_pkg::paddr_u   lc_addr_in;
  mem_types_pkg::line_t    lc_value_in;
  logic                    lc_ready_out;

  logic [31:0] exp_resp[$];  // fetch addresses in acceptance order
  logic [31:0] exp_req[$];   // predicted miss requests, line aligned
  int          pass_cnt      = 0;
  int          fail_cnt      = 0;
  int          test_fails    = 0;
  int          llc_req_count = 0;
  string       cur_test;

  // lines 10, 34 and 24010 share index 10, lines 11 and 35 share index 11
  logic [25:0] pool [8] = '{26'd10, 26'd34, 26'd24010, 26'd11,
                            26'd35, 26'd12, 26'd40, 26'd23};

  `include "l1i_ref_model.svh"

  l1i_cache #(.NUM_LINES(NUM_LINES)) DUT (.*);

  initial begin
    clk_in = 1'b0;
    forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
  end

  task automatic flag_error(input string msg);
    $display("%s: %s", cur_test, msg);
    fail_cnt++;
    test_fails++;
  endtask

  task automatic check_eq(input string what, input logic [511:0] expected,
                          input logic [511:0] actual);
    assert (actual === expected) begin
      pass_cnt++;
    end else begin
      $display("CHECK FAILED %s %s: expected %0h, actual %0h",
               cur_test, what, expected, actual);
      fail_cnt++;
      test_fails++;
    end
  endtask

  task automatic wait_cycles(input int unsigned n);
    repeat (n) begin
      @(posedge clk_in);
      #1;
    end
  endtask

  // offer one fetch and hold it until accepted, model updated in order
  task automatic fetch(input logic [31:0] a);
    l0_valid_in     = 1'b1;
    l0_addr_in.word = a;
    @(negedge clk_in);
    while (l0_ready_out !== 1'b1) @(negedge clk_in);
    exp_resp.push_back(a);
    if (model_access(a[31:6])) exp_req.push_back({a[31:6], 6'b0});
    @(posedge clk_in);
    #1;
    l0_valid_in = 1'b0;
  endtask

  task automatic drain();
    while (exp_resp.size() != 0) begin
      @(posedge clk_in);
      #1;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test   = name;
    test_fails = 0;
  endtask

  task automatic end_test();
    drain();
    wait_cycles(2);
    assert (exp_req.size() == 0) else begin
      flag_error($sformatf("%0d predicted llc requests never appeared", exp_req.size()));
    end
    $display("%s finished with %0d errors", cur_test, test_fails);
  endtask

  // lines with four distinct indices
  task automatic fetch_distinct_set();
    for (int i = 0; i < 4; i++) begin
      fetch({pool[4+i], 6'($urandom_range(0, 63))});
    end
  endtask

  initial begin : l0_backpressure
    forever begin
      @(posedge clk_in);
      #1;
      l0_ready_in = ($urandom_range(0, 3) != 0);
    end
  end

  initial begin : llc_responder
    logic [31:0] req_addr;
    forever begin
      @(posedge clk_in);
      #1;
      if (lc_valid_out === 1'b1) begin
        req_addr = lc_addr_out;
        wait_cycles($urandom_range(0, 3));
        lc_ready_in = 1'b1;
        @(posedge clk_in);
        #1;
        lc_ready_in = 1'b0;
        llc_req_count++;
        assert (exp_req.size() != 0) begin
          check_eq("llc request address", 512'(exp_req.pop_front()), 512'(req_addr));
        end else begin
          flag_error($sformatf("llc request %h for a fetch predicted to hit", req_addr));
        end
        wait_cycles($urandom_range(1, 6));
        lc_valid_in     = 1'b1;
        lc_addr_in.word = req_addr;
        lc_value_in     = line_pattern(req_addr[31:6]);
        @(negedge clk_in);
        while (lc_ready_out !== 1'b1) @(negedge clk_in);
        @(posedge clk_in);
        #1;
        lc_valid_in = 1'b0;
      end
    end
  end

  // outputs are steady between the input drive and the next edge
  always @(negedge clk_in) begin : resp_monitor
    logic [31:0] exp_a;
    if (l0_valid_out === 1'b1 && l0_ready_in === 1'b1) begin
      assert (exp_resp.size() != 0) begin
        exp_a = exp_resp.pop_front();
        check_eq("response address", 512'(exp_a), 512'(l0_addr_out.word));
        check_eq("response data", line_pattern(exp_a[31:6]), l0_value_out);
      end else begin
        flag_error($sformatf("response %h with no fetch outstanding", l0_addr_out.word));
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the cache stopped responding", WATCHDOG_NS);
    $display("test failed");
    $finish;
  end

  initial begin : main_seq
    int base;
    rst_N_in    = 1'b0;
    flush_in    = 1'b0;
    l0_valid_in = 1'b0;
    l0_addr_in  = '0;
    l0_ready_in = 1'b0;
    lc_ready_in = 1'b0;
    lc_valid_in = 1'b0;
    lc_addr_in  = '0;
    lc_value_in = '0;
    void'($urandom(48));

    begin_test("reset_check");
    repeat (3) @(posedge clk_in);
    #1;
    check_eq("l0_valid_out in reset", '0, 512'(l0_valid_out));
    check_eq("lc_valid_out in reset", '0, 512'(lc_valid_out));
    check_eq("lc_ready_out in reset", '0, 512'(lc_ready_out));
    check_eq("l0_ready_out in reset", '0, 512'(l0_ready_out));
    rst_N_in = 1'b1;
    wait_cycles(1);
    check_eq("l0_ready_out after reset", 512'(1), 512'(l0_ready_out));
    end_test();

    // cold cache, A and B share one index
    begin_test("conflict_evict");
    base = llc_req_count;
    fetch({pool[0], 6'h04});
    fetch({pool[0], 6'h20});
    fetch({pool[0], 6'h3c});
    fetch({pool[1], 6'h00});
    fetch({pool[0], 6'h10});
    fetch({pool[1], 6'h08});
    drain();
    check_eq("llc requests for A A A B A B", 512'(4), 512'(llc_req_count - base));
    end_test();

    begin_test("random_traffic");
    for (int n = 0; n < RAND_FETCHES; n++) begin
      fetch({pool[$urandom_range(0, 7)], 6'($urandom_range(0, 63))});
      wait_cycles($urandom_range(0, 2));
    end
    end_test();

    begin_test("flush_refetch");
    fetch_distinct_set();
    drain();
    base = llc_req_count;
    fetch_distinct_set();  // all resident now
    drain();
    check_eq("llc requests on repeat", '0, 512'(llc_req_count - base));
    wait_cycles(2);
    flush_in = 1'b1;
    model_flush();
    wait_cycles(1);
    flush_in = 1'b0;
    base = llc_req_count;
    fetch_distinct_set();
    drain();
    check_eq("llc requests after flush", 512'(4), 512'(llc_req_count - base));
    end_test();

    $display("checks: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
